//--- rtl/maze_pkg.sv
// scene geometry, host bus types and the register map
// tile size must stay a power of two for the local pixel counters
package maze_pkg;

    localparam int GRID_W = 10;
    localparam int GRID_H = 15;
    localparam int TILE_PX = 4;
    localparam int SCREEN_W = GRID_W * TILE_PX;
    localparam int SCREEN_H = GRID_H * TILE_PX;
    localparam int PIXEL_BYTES = 3 * SCREEN_W * SCREEN_H;

    // horizontal walls sit between rows, vertical walls between columns
    localparam int H_WALL_BITS = (GRID_H - 1) * GRID_W;
    localparam int V_WALL_BITS = GRID_H * (GRID_W - 1);
    localparam int WALL_WORDS = 5;

    typedef struct packed {
        logic [H_WALL_BITS-1:0] h_walls;
        logic [V_WALL_BITS-1:0] v_walls;
    } maze_walls_t;

    // element 0 is the first byte sent for a wall pixel
    localparam logic [2:0][7:0] WALL_COLOR = {8'hd5, 8'h7b, 8'h3a};

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [7:0] REG_CTRL = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_HWALL0 = 8'h10;
    localparam logic [7:0] REG_VWALL0 = 8'h30;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_INIT,
        CTRL_SCENE,
        CTRL_DRAIN
    } ctrl_state_e;

endpackage

//--- rtl/tft_pkg.sv
// panel link definitions for an 18-bit colour panel
// compile after maze_pkg, the window bytes come from its screen size
// no delays follow SWRESET or SLPOUT, a real panel needs them
package tft_pkg;

    // dc is 0 for a command byte and 1 for a data byte
    typedef struct packed {
        logic       dc;
        logic [7:0] data;
    } tft_byte_t;

    typedef struct packed {
        logic cs_n;
        logic sclk;
        logic mosi;
        logic dc;
    } tft_pins_t;

    typedef enum logic [7:0] {
        SWRESET = 8'h01,
        SLPOUT  = 8'h11,
        DISPON  = 8'h29,
        CASET   = 8'h2a,
        PASET   = 8'h2b,
        RAMWR   = 8'h2c,
        COLMOD  = 8'h3a
    } tft_cmd_e;

    localparam int INIT_LEN = 16;

    localparam tft_byte_t INIT_TABLE [INIT_LEN] = '{
        '{1'b0, SWRESET},
        '{1'b0, SLPOUT},
        '{1'b0, COLMOD},
        '{1'b1, 8'h66},
        '{1'b0, DISPON},
        '{1'b0, CASET},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'(maze_pkg::SCREEN_W - 1)},
        '{1'b0, PASET},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'(maze_pkg::SCREEN_H - 1)},
        '{1'b0, RAMWR}
    };

endpackage

//--- rtl/maze_apb_regs.sv
// APB3 register block, zero wait states
// wall words cannot be written while a frame is running
`timescale 1ns/100ps

module maze_apb_regs
(
    input  logic                   clk,
    input  logic                   rst,
    input  maze_pkg::apb_req_t     apb_in,
    output maze_pkg::apb_rsp_t     apb_out,
    input  logic                   busy,
    input  logic                   frame_done,
    output logic                   start,
    output maze_pkg::maze_walls_t  walls
);
    import maze_pkg::*;

    logic                     access;
    logic                     ctrl_hit;
    logic                     status_hit;
    logic                     h_hit;
    logic                     v_hit;
    logic                     wall_err;
    logic [7:0]               h_off;
    logic [7:0]               v_off;
    logic [2:0]               h_idx;
    logic [2:0]               v_idx;
    logic [H_WALL_BITS-1:0]   h_reg;
    logic [V_WALL_BITS-1:0]   v_reg;
    logic [WALL_WORDS*32-1:0] h_view;
    logic [WALL_WORDS*32-1:0] v_view;
    logic [31:0]              rdata;
    logic                     done_q;

    assign access = apb_in.psel && apb_in.penable;

    // an address below the window wraps to a large offset and misses
    assign h_off = apb_in.paddr - REG_HWALL0;
    assign v_off = apb_in.paddr - REG_VWALL0;
    assign h_idx = h_off[4:2];
    assign v_idx = v_off[4:2];
    assign h_hit = (h_off < 8'(4 * WALL_WORDS)) && (h_off[1:0] == 2'b00);
    assign v_hit = (v_off < 8'(4 * WALL_WORDS)) && (v_off[1:0] == 2'b00);
    assign ctrl_hit = (apb_in.paddr == REG_CTRL);
    assign status_hit = (apb_in.paddr == REG_STATUS);

    assign wall_err = apb_in.pwrite && (h_hit || v_hit) && busy;

    // bits past the end of the last word read back as zero
    assign h_view = {{(WALL_WORDS * 32 - H_WALL_BITS){1'b0}}, h_reg};
    assign v_view = {{(WALL_WORDS * 32 - V_WALL_BITS){1'b0}}, v_reg};

    always_comb
    begin
        rdata = '0;
        if (status_hit)
            rdata = {30'd0, done_q, busy};
        else if (h_hit)
            rdata = h_view[h_idx*32 +: 32];
        else if (v_hit)
            rdata = v_view[v_idx*32 +: 32];
    end

    assign apb_out = '{
        prdata: rdata,
        pready: 1'b1,
        pslverr: access && (!(ctrl_hit || status_hit || h_hit || v_hit) || wall_err)
    };

    always_ff @(posedge clk)
    begin
        if (access && apb_in.pwrite && !busy)
        begin
            for (int b = 0; b < 32; b++)
            begin
                if (h_hit && (int'(h_idx) * 32 + b < H_WALL_BITS))
                    h_reg[int'(h_idx) * 32 + b] <= apb_in.pwdata[b];
                if (v_hit && (int'(v_idx) * 32 + b < V_WALL_BITS))
                    v_reg[int'(v_idx) * 32 + b] <= apb_in.pwdata[b];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            start <= access && apb_in.pwrite && ctrl_hit && apb_in.pwdata[0];
            if (start)
                done_q <= 1'b0;
            else if (frame_done)
                done_q <= 1'b1;
        end
    end

    assign walls.h_walls = h_reg;
    assign walls.v_walls = v_reg;

endmodule

//--- rtl/maze_ctrl.sv
// frame sequencer, init bytes first and then the pixel stream
// a start request that arrives during a frame is dropped
`timescale 1ns/100ps

module maze_ctrl
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output logic               busy,
    output logic               frame_done,
    output logic               init_go,
    output logic               scene_go,
    input  logic               init_last,
    input  logic               scene_last,
    input  tft_pkg::tft_byte_t init_byte,
    input  tft_pkg::tft_byte_t scene_byte,
    input  logic               init_valid,
    input  logic               scene_valid,
    output logic               init_ready,
    output logic               scene_ready,
    output tft_pkg::tft_byte_t tx_byte,
    output logic               tx_valid,
    input  logic               tx_ready,
    input  logic               tx_idle
);
    import maze_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            CTRL_IDLE:
                if (start)
                    state_next = CTRL_INIT;
            CTRL_INIT:
                if (init_last)
                    state_next = CTRL_SCENE;
            CTRL_SCENE:
                if (scene_last)
                    state_next = CTRL_DRAIN;
            // the last pixel byte is still on the wire here
            CTRL_DRAIN:
                if (tx_idle)
                    state_next = CTRL_IDLE;
            default:
                state_next = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= CTRL_IDLE;
            init_go <= 1'b0;
            scene_go <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            state <= state_next;
            init_go <= (state == CTRL_IDLE) && start;
            scene_go <= (state == CTRL_INIT) && init_last;
            frame_done <= (state == CTRL_DRAIN) && tx_idle;
        end
    end

    assign busy = (state != CTRL_IDLE);

    // only the source of the current phase sees the serializer
    assign tx_byte = (state == CTRL_SCENE) ? scene_byte : init_byte;
    assign tx_valid = ((state == CTRL_INIT) && init_valid) ||
                      ((state == CTRL_SCENE) && scene_valid);
    assign init_ready = (state == CTRL_INIT) && tx_ready;
    assign scene_ready = (state == CTRL_SCENE) && tx_ready;

endmodule

//--- rtl/tft_init_seq.sv
// walks the init and window command table once per go pulse
`timescale 1ns/100ps

module tft_init_seq
(
    input  logic               clk,
    input  logic               rst,
    input  logic               go,
    output tft_pkg::tft_byte_t out_byte,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               last_sent
);
    import tft_pkg::*;

    logic [$clog2(INIT_LEN)-1:0] idx;
    logic                        active;
    logic                        at_end;

    assign at_end = (int'(idx) == INIT_LEN - 1);
    assign out_valid = active;
    assign out_byte = INIT_TABLE[idx];
    assign last_sent = active && out_ready && at_end;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active <= 1'b0;
            idx <= '0;
        end
        else if (go)
        begin
            active <= 1'b1;
            idx <= '0;
        end
        else if (active && out_ready)
        begin
            if (at_end)
                active <= 1'b0;
            else
                idx <= idx + 1'b1;
        end
    end

endmodule

//--- rtl/scene_exhibitor.sv
// raster scan of the maze, three colour bytes per pixel, all as data
// walls must not change between go and last_sent
// the outer border of the grid is never drawn
`timescale 1ns/100ps

module scene_exhibitor
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  maze_pkg::maze_walls_t walls,
    output tft_pkg::tft_byte_t    out_byte,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic                  last_sent
);
    import maze_pkg::*;

    logic                       active;
    logic [$clog2(GRID_W)-1:0]  tx;
    logic [$clog2(GRID_H)-1:0]  ty;
    logic [$clog2(TILE_PX)-1:0] lx;
    logic [$clog2(TILE_PX)-1:0] ly;
    logic [1:0]                 cidx;
    logic [7:0]                 v_left;
    logic [7:0]                 v_right;
    logic [7:0]                 h_top;
    logic [7:0]                 h_bottom;
    logic                       wall_px;
    logic                       step;
    logic                       lx_end;
    logic                       row_end;
    logic                       ly_end;
    logic                       frame_end;

    // bit positions of the four walls around the current tile
    assign v_left = 8'(ty * (GRID_W - 1) + tx - 1);
    assign v_right = 8'(ty * (GRID_W - 1) + tx);
    assign h_top = 8'((ty - 1) * GRID_W + tx);
    assign h_bottom = 8'(ty * GRID_W + tx);

    // the tile range checks keep the out-of-grid indices from mattering
    assign wall_px =
        (lx == 0 && tx != 0 && walls.v_walls[v_left]) ||
        (lx == TILE_PX - 1 && tx < GRID_W - 1 && walls.v_walls[v_right]) ||
        (ly == 0 && ty != 0 && walls.h_walls[h_top]) ||
        (ly == TILE_PX - 1 && ty < GRID_H - 1 && walls.h_walls[h_bottom]);

    assign out_valid = active;
    assign out_byte.dc = 1'b1;
    assign out_byte.data = wall_px ? WALL_COLOR[cidx] : 8'h00;

    assign step = active && out_ready;
    assign lx_end = (lx == TILE_PX - 1);
    assign row_end = lx_end && (tx == GRID_W - 1);
    assign ly_end = (ly == TILE_PX - 1);
    assign frame_end = (cidx == 2'd2) && row_end && ly_end && (ty == GRID_H - 1);
    assign last_sent = step && frame_end;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active <= 1'b0;
            cidx <= '0;
            lx <= '0;
            tx <= '0;
            ly <= '0;
            ty <= '0;
        end
        else if (go)
        begin
            active <= 1'b1;
            cidx <= '0;
            lx <= '0;
            tx <= '0;
            ly <= '0;
            ty <= '0;
        end
        else if (step)
        begin
            if (cidx != 2'd2)
                cidx <= cidx + 1'b1;
            else
            begin
                cidx <= '0;
                lx <= lx + 1'b1;
                if (lx_end)
                    tx <= (tx == GRID_W - 1) ? '0 : tx + 1'b1;
                if (row_end)
                begin
                    ly <= ly + 1'b1;
                    if (ly_end)
                        ty <= ty + 1'b1;
                end
                if (frame_end)
                    active <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/tft_spi_tx.sv
// SPI byte serializer, sclk at clk/2, MSB first, 16 clocks per byte
// cs_n rises for one idle clock between back-to-back bytes
`timescale 1ns/100ps

module tft_spi_tx
(
    input  logic               clk,
    input  logic               rst,
    input  tft_pkg::tft_byte_t in_byte,
    input  logic               in_valid,
    output logic               in_ready,
    output logic               idle,
    output tft_pkg::tft_pins_t pins
);
    logic       busy_q;
    logic [3:0] cnt;
    logic [7:0] shreg;
    logic       dc_q;
    logic       take;

    assign in_ready = !busy_q;
    assign idle = !busy_q;
    assign take = in_valid && !busy_q;

    // odd counts are the high half of sclk where the panel samples
    assign pins.cs_n = !busy_q;
    assign pins.sclk = busy_q && cnt[0];
    assign pins.mosi = busy_q && shreg[7];
    assign pins.dc = dc_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy_q <= 1'b0;
            cnt <= '0;
            dc_q <= 1'b0;
        end
        else if (take)
        begin
            busy_q <= 1'b1;
            cnt <= '0;
            dc_q <= in_byte.dc;
        end
        else if (busy_q)
        begin
            cnt <= cnt + 1'b1;
            if (cnt == 4'd15)
                busy_q <= 1'b0;
        end
    end

    // next bit moves up as sclk falls
    always_ff @(posedge clk)
    begin
        if (take)
            shreg <= in_byte.data;
        else if (busy_q && cnt[0])
            shreg <= {shreg[6:0], 1'b0};
    end

endmodule

//--- rtl/maze_display_top.sv
// maze display core, APB3 host side and a write-only SPI panel link
`timescale 1ns/100ps

module maze_display_top
(
    input  logic               clk,
    input  logic               rst,
    input  maze_pkg::apb_req_t apb_in,
    output maze_pkg::apb_rsp_t apb_out,
    output tft_pkg::tft_pins_t pins
);
    import maze_pkg::*;
    import tft_pkg::*;

    maze_walls_t walls;
    logic        start;
    logic        busy;
    logic        frame_done;
    logic        init_go;
    logic        scene_go;
    logic        init_last;
    logic        scene_last;
    tft_byte_t   init_byte;
    tft_byte_t   scene_byte;
    logic        init_valid;
    logic        scene_valid;
    logic        init_ready;
    logic        scene_ready;
    tft_byte_t   tx_byte;
    logic        tx_valid;
    logic        tx_ready;
    logic        tx_idle;

    maze_apb_regs regs0
    (
        .clk        (clk),
        .rst        (rst),
        .apb_in     (apb_in),
        .apb_out    (apb_out),
        .busy       (busy),
        .frame_done (frame_done),
        .start      (start),
        .walls      (walls)
    );

    maze_ctrl ctrl0
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .frame_done  (frame_done),
        .init_go     (init_go),
        .scene_go    (scene_go),
        .init_last   (init_last),
        .scene_last  (scene_last),
        .init_byte   (init_byte),
        .scene_byte  (scene_byte),
        .init_valid  (init_valid),
        .scene_valid (scene_valid),
        .init_ready  (init_ready),
        .scene_ready (scene_ready),
        .tx_byte     (tx_byte),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_idle     (tx_idle)
    );

    tft_init_seq init0
    (
        .clk       (clk),
        .rst       (rst),
        .go        (init_go),
        .out_byte  (init_byte),
        .out_valid (init_valid),
        .out_ready (init_ready),
        .last_sent (init_last)
    );

    scene_exhibitor scene0
    (
        .clk       (clk),
        .rst       (rst),
        .go        (scene_go),
        .walls     (walls),
        .out_byte  (scene_byte),
        .out_valid (scene_valid),
        .out_ready (scene_ready),
        .last_sent (scene_last)
    );

    tft_spi_tx spi0
    (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (tx_byte),
        .in_valid (tx_valid),
        .in_ready (tx_ready),
        .idle     (tx_idle),
        .pins     (pins)
    );

endmodule

//--- verif/maze_display_checker.sv
// watches the panel pins and the APB response of the maze display
// expected bus values come from the testbench and pixel bytes from a wall model
// assumes one frame is fully sent before the walls change
`timescale 1ns/100ps

module maze_display_checker
(
    input  logic                  clk,
    input  logic                  rst,
    input  tft_pkg::tft_pins_t    pins,
    input  maze_pkg::apb_req_t    apb_in,
    input  maze_pkg::apb_rsp_t    apb_out,
    input  maze_pkg::maze_walls_t walls,
    input  logic                  expect_en,
    input  logic                  expect_read,
    input  logic [31:0]           expect_rdata,
    input  logic                  expect_err,
    output int                    errors,
    output int                    frames
);
    import maze_pkg::*;
    import tft_pkg::*;

    localparam int FRAME_BYTES = INIT_LEN + PIXEL_BYTES;

    logic       sclk;
    logic [7:0] shift = '0;
    int         nbits = 0;
    int         byte_idx = 0;
    int         spi_errors = 0;
    int         bus_errors = 0;
    int         pin_errors = 0;

    assign sclk = pins.sclk;
    assign errors = spi_errors + bus_errors + pin_errors;

    // the outer border is never drawn by the wall rule
    function automatic logic [7:0] pixel_byte(input int x, input int y, input int c,
                                              input maze_walls_t w);
        int   tx;
        int   ty;
        int   lx;
        int   ly;
        logic wall;
        tx = x / TILE_PX;
        ty = y / TILE_PX;
        lx = x % TILE_PX;
        ly = y % TILE_PX;
        wall = 1'b0;
        if (lx == 0 && tx > 0 && w.v_walls[ty * (GRID_W - 1) + tx - 1])
            wall = 1'b1;
        if (lx == TILE_PX - 1 && tx < GRID_W - 1 && w.v_walls[ty * (GRID_W - 1) + tx])
            wall = 1'b1;
        if (ly == 0 && ty > 0 && w.h_walls[(ty - 1) * GRID_W + tx])
            wall = 1'b1;
        if (ly == TILE_PX - 1 && ty < GRID_H - 1 && w.h_walls[ty * GRID_W + tx])
            wall = 1'b1;
        if (!wall)
            return 8'h00;
        case (c)
            0: return 8'h3a;
            1: return 8'h7b;
            default: return 8'hd5;
        endcase
    endfunction

    task automatic check_byte(input tft_byte_t got);
        tft_byte_t exp;
        int        pix;
        int        p;
        if (byte_idx < INIT_LEN)
            exp = INIT_TABLE[byte_idx];
        else
        begin
            p = byte_idx - INIT_LEN;
            pix = p / 3;
            exp.dc = 1'b1;
            exp.data = pixel_byte(pix % SCREEN_W, pix / SCREEN_W, p % 3, walls);
        end
        if (got !== exp)
        begin
            spi_errors++;
            $display("MISMATCH time=%0t signal=spi_byte[%0d] ", $time, byte_idx,
                     "expected dc=%b data=%h actual dc=%b data=%h",
                     exp.dc, exp.data, got.dc, got.data);
        end
        byte_idx++;
        if (byte_idx == FRAME_BYTES)
        begin
            byte_idx = 0;
            frames++;
        end
    endtask

    initial
        frames = 0;

    // the panel samples mosi and dc on the rising sclk edge
    always @(posedge sclk)
    begin
        if (!pins.cs_n)
        begin
            shift = {shift[6:0], pins.mosi};
            nbits++;
            if (nbits == 8)
            begin
                check_byte({pins.dc, shift});
                nbits = 0;
            end
        end
    end

    always @(negedge clk)
    begin
        if (rst && pins.cs_n !== 1'b1)
        begin
            pin_errors++;
            $display("MISMATCH time=%0t signal=cs_n expected 1 actual %b", $time, pins.cs_n);
        end
        if (rst && pins.sclk !== 1'b0)
        begin
            pin_errors++;
            $display("MISMATCH time=%0t signal=sclk expected 0 actual %b", $time, pins.sclk);
        end
    end

    // the access phase ends at this edge before the bus moves on
    always @(posedge clk)
    begin
        if (expect_en && apb_in.psel && apb_in.penable)
        begin
            if (expect_read && apb_out.prdata !== expect_rdata)
            begin
                bus_errors++;
                $display("MISMATCH time=%0t signal=prdata addr=%h expected %h actual %h",
                         $time, apb_in.paddr, expect_rdata, apb_out.prdata);
            end
            if (apb_out.pslverr !== expect_err)
            begin
                bus_errors++;
                $display("MISMATCH time=%0t signal=pslverr addr=%h expected %b actual %b",
                         $time, apb_in.paddr, expect_err, apb_out.pslverr);
            end
            if (apb_out.pready !== 1'b1)
            begin
                bus_errors++;
                $display("MISMATCH time=%0t signal=pready addr=%h expected 1 actual %b",
                         $time, apb_in.paddr, apb_out.pready);
            end
        end
    end

endmodule

//--- verif/maze_display_tb.sv
// two frames over random walls from a fixed seed plus register and error checks
// the run ends on its own after a cycle limit sized for two frames
`timescale 1ns/100ps

module maze_display_tb;
    import maze_pkg::*;
    import tft_pkg::*;

    localparam int CYCLE_LIMIT = 2 * (INIT_LEN + PIXEL_BYTES) * 18 + 20000;

    logic        clk;
    logic        rst;
    apb_req_t    apb_in;
    apb_rsp_t    apb_out;
    tft_pins_t   pins;
    maze_walls_t model_walls;
    logic        expect_en;
    logic        expect_read;
    logic [31:0] expect_rdata;
    logic        expect_err;
    int          chk_errors;
    int          frames_seen;
    int          tb_errors = 0;
    int          cycles = 0;

    maze_display_top dut0
    (
        .clk     (clk),
        .rst     (rst),
        .apb_in  (apb_in),
        .apb_out (apb_out),
        .pins    (pins)
    );

    maze_display_checker chk0
    (
        .clk          (clk),
        .rst          (rst),
        .pins         (pins),
        .apb_in       (apb_in),
        .apb_out      (apb_out),
        .walls        (model_walls),
        .expect_en    (expect_en),
        .expect_read  (expect_read),
        .expect_rdata (expect_rdata),
        .expect_err   (expect_err),
        .errors       (chk_errors),
        .frames       (frames_seen)
    );

    always #20 clk = ~clk;

    // one APB3 transfer made of a setup cycle and an access cycle
    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              input logic chk_data, input logic [31:0] exp_data,
                              input logic exp_error, output logic [31:0] rdata);
        @(posedge clk);
        apb_in <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_in.penable <= 1'b1;
        expect_en <= 1'b1;
        expect_read <= chk_data;
        expect_rdata <= exp_data;
        expect_err <= exp_error;
        @(negedge clk);
        rdata = apb_out.prdata;
        @(posedge clk);
        apb_in.psel <= 1'b0;
        apb_in.penable <= 1'b0;
        expect_en <= 1'b0;
    endtask

    // bits past the bitmap read back as zero in a wall word
    function automatic logic [31:0] wall_word(input logic horiz, input int idx);
        logic [31:0] w;
        int          b;
        w = '0;
        for (b = 0; b < 32; b++)
        begin
            if (horiz && idx * 32 + b < H_WALL_BITS)
                w[b] = model_walls.h_walls[idx * 32 + b];
            if (!horiz && idx * 32 + b < V_WALL_BITS)
                w[b] = model_walls.v_walls[idx * 32 + b];
        end
        return w;
    endfunction

    task automatic load_walls();
        logic [31:0] hw;
        logic [31:0] vw;
        logic [31:0] rd;
        int          i;
        int          b;
        for (i = 0; i < WALL_WORDS; i++)
        begin
            hw = $urandom;
            vw = $urandom;
            bus_access(1'b1, REG_HWALL0 + 8'(4 * i), hw, 1'b0, '0, 1'b0, rd);
            bus_access(1'b1, REG_VWALL0 + 8'(4 * i), vw, 1'b0, '0, 1'b0, rd);
            for (b = 0; b < 32; b++)
            begin
                if (i * 32 + b < H_WALL_BITS)
                    model_walls.h_walls[i * 32 + b] = hw[b];
                if (i * 32 + b < V_WALL_BITS)
                    model_walls.v_walls[i * 32 + b] = vw[b];
            end
        end
        for (i = 0; i < WALL_WORDS; i++)
        begin
            bus_access(1'b0, REG_HWALL0 + 8'(4 * i), '0, 1'b1, wall_word(1'b1, i), 1'b0, rd);
            bus_access(1'b0, REG_VWALL0 + 8'(4 * i), '0, 1'b1, wall_word(1'b0, i), 1'b0, rd);
        end
    endtask

    task automatic wait_frame(input int expected_frames);
        logic [31:0] st;
        do
        begin
            repeat (100) @(posedge clk);
            bus_access(1'b0, REG_STATUS, '0, 1'b0, '0, 1'b0, st);
        end
        while (!st[1]);
        // done set and busy clear once the frame is over
        bus_access(1'b0, REG_STATUS, '0, 1'b1, 32'h2, 1'b0, st);
        if (frames_seen != expected_frames)
        begin
            tb_errors++;
            $display("MISMATCH time=%0t signal=frames_seen expected %0d actual %0d",
                     $time, expected_frames, frames_seen);
        end
    endtask

    task automatic end_run(input logic hung);
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (!hung && chk_errors == 0 && tb_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, the frame never finished", cycles);
            end_run(1'b1);
        end
    end

    initial
    begin
        logic [31:0] rd;
        clk = 1'b0;
        rst = 1'b1;
        apb_in = '0;
        model_walls = '0;
        expect_en = 1'b0;
        expect_read = 1'b0;
        expect_rdata = '0;
        expect_err = 1'b0;
        void'($urandom(32'h30db937c));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        bus_access(1'b0, REG_STATUS, '0, 1'b1, 32'h0, 1'b0, rd);
        load_walls();
        bus_access(1'b0, 8'h08, '0, 1'b0, '0, 1'b1, rd);
        bus_access(1'b1, REG_CTRL, 32'h1, 1'b0, '0, 1'b0, rd);
        bus_access(1'b0, REG_STATUS, '0, 1'b1, 32'h1, 1'b0, rd);
        // a wall write during the frame is refused and leaves the bitmap alone
        bus_access(1'b1, REG_HWALL0, $urandom, 1'b0, '0, 1'b1, rd);
        bus_access(1'b0, REG_HWALL0, '0, 1'b1, wall_word(1'b1, 0), 1'b0, rd);
        wait_frame(1);
        load_walls();
        bus_access(1'b1, REG_CTRL, 32'h1, 1'b0, '0, 1'b0, rd);
        bus_access(1'b0, REG_STATUS, '0, 1'b1, 32'h1, 1'b0, rd);
        wait_frame(2);
        end_run(1'b0);
    end

endmodule

//--- maze_display.f
rtl/maze_pkg.sv
rtl/tft_pkg.sv
rtl/maze_apb_regs.sv
rtl/maze_ctrl.sv
rtl/tft_init_seq.sv
rtl/scene_exhibitor.sv
rtl/tft_spi_tx.sv
rtl/maze_display_top.sv
verif/maze_display_checker.sv
verif/maze_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the maze display testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module maze_display_tb \
    -f maze_display.f -Mdir obj_dir -o maze_display_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/maze_display_sim > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
